// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tbFletcher \
		-f sources.f -o simFletcher
	./obj_dir/simFletcher | tee /dev/stderr | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

// ==== checksumResult.sv ====
`timescale 1ns/1ps

module checksumResult
    import fletcherPkg::*;
#(
    parameter int Width = 32
) (
    input  logic [Width-1:0]        checksum,
    input  logic [Width-1:0]        expected,
    input  logic [15:0]             count,
    input  logic [regAddrWidth-1:0] rdAddr,
    output logic [31:0]             rdData
);
    logic        match;
    logic [31:0] status;

    // also high straight after reset, zero equals zero.
    assign match = (checksum == expected);

    // count in the upper half, flag in bit 0.
    assign status = {count, 15'd0, match};

    always_comb begin
        case (rdAddr)
            regCtrl: begin
                rdData = status;
            end
            regData: begin
                rdData = '0;                  // data port is write-only.
            end
            regSum: begin
                rdData = 32'(checksum);       // truncated or zero-extended.
            end
            regExpect: begin
                rdData = 32'(expected);
            end
            default: begin
                rdData = '0;
            end
        endcase
    end

endmodule

// ==== fletcherEngine.sv ====
`timescale 1ns/1ps

module fletcherEngine #(
    parameter int Width = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 feed,
    input  logic [Width/2-1:0]   word,
    output logic [Width-1:0]     checksum,
    output logic [15:0]          count
);
    localparam int HalfWidth = Width / 2;

    // 2^half - 1 with one spare bit for the borrow.
    localparam logic [HalfWidth:0] modulus = {1'b0, {HalfWidth{1'b1}}};

    logic [HalfWidth:0] aSub;     // A + input - modulus.
    logic [HalfWidth:0] aSum;     // A + input.
    logic [HalfWidth:0] bSub;     // B + A - modulus.
    logic [HalfWidth:0] bSum;     // B + A.
    logic [HalfWidth:0] aCur;
    logic [HalfWidth:0] bCur;
    logic               feedDly;  // B trails A by one cycle.

    // a set top bit on the subtracted candidate means it went negative,
    // so the plain sum is already below the modulus.
    assign aCur = aSub[HalfWidth] ? aSum : aSub;
    assign bCur = bSub[HalfWidth] ? bSum : bSub;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            aSub    <= '0;
            aSum    <= '0;
            bSub    <= '0;
            bSum    <= '0;
            feedDly <= 1'b0;
            count   <= '0;
        end else begin
            feedDly <= feed;

            if (feed) begin
                aSub  <= aCur + {1'b0, word} - modulus;
                aSum  <= aCur + {1'b0, word};
                count <= count + 16'd1;   // wraps at 16 bits.
            end

            if (feedDly) begin
                bSub <= bCur + aCur - modulus;   // aCur is the freshly stored A.
                bSum <= bCur + aCur;
            end
        end
    end

    // selected values stay below 2^half - 1, so the top bit is dropped.
    assign checksum = {bCur[HalfWidth-1:0], aCur[HalfWidth-1:0]};

endmodule

// ==== fletcherPkg.sv ====
package fletcherPkg;

    // word address width of the register map.
    localparam int regAddrWidth = 2;

    // control on write, status on read.
    // write: bit 0 set clears both sums and the word count.
    // read: bit 0 is the match flag, bits 31..16 the word count.
    localparam logic [regAddrWidth-1:0] regCtrl = 2'd0;

    // write feeds the low half-width bits as one data word, read gives 0.
    localparam logic [regAddrWidth-1:0] regData = 2'd1;

    // read-only checksum {B,A}.
    localparam logic [regAddrWidth-1:0] regSum = 2'd2;

    // expected checksum, read and write.
    localparam logic [regAddrWidth-1:0] regExpect = 2'd3;

endpackage

// ==== fletcherTop.sv ====
`timescale 1ns/1ps

module fletcherTop
    import fletcherPkg::*;
#(
    parameter int Width = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [regAddrWidth-1:0] adr,
    input  logic [31:0]             datWr,
    output logic [31:0]             datRd,
    output logic                    ack
);
    logic                    clear;
    logic                    feed;
    logic [Width/2-1:0]      word;
    logic [Width-1:0]        expected;
    logic [regAddrWidth-1:0] rdAddr;
    logic [Width-1:0]        checksum;
    logic [15:0]             count;
    logic [31:0]             rdData;

    wbRegDecode #(
        .Width   (Width)
    ) uDecode (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datWr   (datWr),
        .rdData  (rdData),
        .ack     (ack),
        .datRd   (datRd),
        .clear   (clear),
        .feed    (feed),
        .word    (word),
        .expected(expected),
        .rdAddr  (rdAddr)
    );

    fletcherEngine #(
        .Width   (Width)
    ) uEngine (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .feed    (feed),
        .word    (word),
        .checksum(checksum),
        .count   (count)
    );

    checksumResult #(
        .Width   (Width)
    ) uResult (
        .checksum(checksum),
        .expected(expected),
        .count   (count),
        .rdAddr  (rdAddr),
        .rdData  (rdData)
    );

endmodule

// ==== sources.f ====
fletcherPkg.sv
wbRegDecode.sv
fletcherEngine.sv
checksumResult.sv
fletcherTop.sv
tbFletcher.sv

// ==== tbFletcher.sv ====
`timescale 1ns/1ps

module tbFletcher
    import fletcherPkg::*;
();
    localparam int opWrite      = 0;
    localparam int opRead       = 1;
    localparam int opFeedRand   = 2;   // data column holds the number of words.
    localparam int opWriteModel = 3;   // model checksum xor data into regExpect.
    localparam int ackTimeout   = 20;

    logic                    clk;
    logic                    rst;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [regAddrWidth-1:0] adr;
    logic [31:0]             datWr;
    logic [31:0]             datRd;
    logic                    ack;

    // stimulus table, one row spread over the queues.
    int                      rowOp[$];
    logic [regAddrWidth-1:0] rowAdr[$];
    logic [31:0]             rowDat[$];
    logic [31:0]             rowExp[$];
    bit                      rowModel[$];

    // software Fletcher-32 state.
    logic [15:0] modA;
    logic [15:0] modB;
    logic [15:0] modCount;
    logic [31:0] modExpect;

    int checks;
    int errors;

    fletcherTop #(
        .Width(32)
    ) dut (
        .clk  (clk),
        .rst  (rst),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .datWr(datWr),
        .datRd(datRd),
        .ack  (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic addRow(input int op, input logic [regAddrWidth-1:0] addr,
                          input logic [31:0] data, input logic [31:0] expVal,
                          input bit useModel);
        rowOp.push_back(op);
        rowAdr.push_back(addr);
        rowDat.push_back(data);
        rowExp.push_back(expVal);
        rowModel.push_back(useModel);
    endtask

    task automatic modelFeed(input logic [15:0] w);
        int sumA;
        int sumB;
        sumA = (int'(modA) + int'(w)) % 65535;
        modA = 16'(sumA);
        sumB = (int'(modB) + int'(modA)) % 65535;   // B takes the new A.
        modB = 16'(sumB);
        modCount = modCount + 16'd1;
    endtask

    task automatic modelWrite(input logic [regAddrWidth-1:0] addr, input logic [31:0] data);
        if (addr == regCtrl && data[0]) begin
            modA     = '0;
            modB     = '0;
            modCount = '0;
        end else if (addr == regData) begin
            modelFeed(data[15:0]);
        end else if (addr == regExpect) begin
            modExpect = data;
        end
    endtask

    function automatic logic [31:0] modelRead(input logic [regAddrWidth-1:0] addr);
        logic match;
        match = ({modB, modA} == modExpect);
        case (addr)
            regCtrl:   return {modCount, 15'd0, match};
            regSum:    return {modB, modA};
            regExpect: return modExpect;
            default:   return 32'd0;
        endcase
    endfunction

    function automatic string regName(input logic [regAddrWidth-1:0] addr);
        case (addr)
            regCtrl:   return "regCtrl";
            regData:   return "regData";
            regSum:    return "regSum";
            default:   return "regExpect";
        endcase
    endfunction

    // one classic cycle with stb still held on the edge after ack,
    // then checks that ack drops after a single clock and does not come back.
    task automatic transfer(input bit write, input logic [regAddrWidth-1:0] addr,
                            input logic [31:0] data, output logic [31:0] rdVal);
        int waited;
        bit gotAck;
        waited = 0;
        gotAck = 1'b0;
        rdVal  = 'x;
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        datWr = data;
        while (!gotAck && waited < ackTimeout) begin
            @(posedge clk);
            #1;
            waited++;
            if (ack) begin
                gotAck = 1'b1;
                rdVal  = datRd;
            end
        end
        if (gotAck) begin
            @(posedge clk);   // stb still high on the edge that ends ack.
            #1;
            if (ack) begin
                $display("Error at %0t: ack stayed high for more than one cycle on %s",
                         $time, regName(addr));
                errors++;
            end
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        checks++;
        if (!gotAck) begin
            $display("Error at %0t: no ack within %0d cycles on %s", $time, ackTimeout,
                     regName(addr));
            errors++;
        end else begin
            @(posedge clk);
            #1;
            if (ack) begin
                $display("Error at %0t: held stb started a second transfer on %s",
                         $time, regName(addr));
                errors++;
            end
        end
    endtask

    task automatic wbWrite(input logic [regAddrWidth-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        transfer(1'b1, addr, data, unused);
    endtask

    task automatic wbRead(input logic [regAddrWidth-1:0] addr, output logic [31:0] data);
        transfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic buildTable();
        int n;
        // after reset.
        addRow(opRead, regSum, 0, 32'h0000_0000, 0);
        addRow(opRead, regCtrl, 0, 32'h0000_0001, 0);
        addRow(opRead, regData, 0, 32'h0000_0000, 0);
        addRow(opRead, regExpect, 0, 32'h0000_0000, 0);
        // "abcd" little-endian.
        addRow(opWrite, regData, 32'h0000_6261, 0, 0);
        addRow(opWrite, regData, 32'h0000_6463, 0, 0);
        addRow(opRead, regSum, 0, 32'h2926_C6C4, 0);
        addRow(opRead, regSum, 0, 0, 1);
        addRow(opRead, regCtrl, 0, 0, 1);
        // from a cleared state, so the first A sum equals the modulus.
        // upper bus bits must be ignored.
        addRow(opWrite, regCtrl, 32'h0000_0001, 0, 0);
        for (n = 0; n < 8; n++) begin
            addRow(opWrite, regData, 32'hABCD_FFFF, 0, 0);
            addRow(opWrite, regData, 32'h0000_FFFE, 0, 0);
            addRow(opRead, regSum, 0, 0, 1);
        end
        // random stream from a cleared state.
        addRow(opWrite, regCtrl, 32'h0000_0001, 0, 0);
        addRow(opFeedRand, regData, 40, 0, 0);
        addRow(opRead, regSum, 0, 0, 1);
        addRow(opRead, regCtrl, 0, 0, 1);
        // match flag.
        addRow(opWriteModel, regExpect, 32'h0000_0000, 0, 0);
        addRow(opRead, regCtrl, 0, 32'h0028_0001, 0);
        addRow(opRead, regExpect, 0, 0, 1);
        addRow(opWriteModel, regExpect, 32'h0000_0100, 0, 0);
        addRow(opRead, regCtrl, 0, 32'h0028_0000, 0);
        addRow(opRead, regExpect, 0, 0, 1);
        // clear and restart.
        addRow(opWrite, regCtrl, 32'h0000_0001, 0, 0);
        addRow(opRead, regSum, 0, 32'h0000_0000, 0);
        addRow(opRead, regCtrl, 0, 32'h0000_0000, 0);
        addRow(opWrite, regData, 32'h0000_6261, 0, 0);
        addRow(opWrite, regData, 32'h0000_6463, 0, 0);
        addRow(opRead, regSum, 0, 32'h2926_C6C4, 0);
        addRow(opRead, regCtrl, 0, 0, 1);
    endtask

    initial begin
        int          i;
        int          k;
        logic [31:0] got;
        logic [31:0] want;
        logic [31:0] word;
        void'($urandom(80));
        rst       = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        datWr     = '0;
        modA      = '0;
        modB      = '0;
        modCount  = '0;
        modExpect = '0;
        checks    = 0;
        errors    = 0;
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (i = 0; i < rowOp.size(); i++) begin
            case (rowOp[i])
                opWrite: begin
                    wbWrite(rowAdr[i], rowDat[i]);
                    modelWrite(rowAdr[i], rowDat[i]);
                end
                opFeedRand: begin
                    for (k = 0; k < int'(rowDat[i]); k++) begin
                        word = $urandom;              // upper half is noise.
                        wbWrite(regData, word);
                        modelWrite(regData, word);
                    end
                end
                opWriteModel: begin
                    word = modelRead(regSum) ^ rowDat[i];
                    wbWrite(regExpect, word);
                    modelWrite(regExpect, word);
                end
                default: begin
                    wbRead(rowAdr[i], got);
                    want = rowModel[i] ? modelRead(rowAdr[i]) : rowExp[i];
                    checks++;
                    if (got !== want) begin
                        $display("Fail at %0t: datRd (%s) expected %h got %h", $time,
                                 regName(rowAdr[i]), want, got);
                        errors++;
                    end
                    // a reduced half never equals the modulus itself.
                    if (rowAdr[i] == regSum && (got[15:0] == 16'hFFFF ||
                                                got[31:16] == 16'hFFFF)) begin
                        $display("Error at %0t: a checksum half reads ffff", $time);
                        errors++;
                    end
                end
            endcase
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== wbRegDecode.sv ====
`timescale 1ns/1ps

module wbRegDecode
    import fletcherPkg::*;
#(
    parameter int Width = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [regAddrWidth-1:0] adr,
    input  logic [31:0]             datWr,
    input  logic [31:0]             rdData,
    output logic                    ack,
    output logic [31:0]             datRd,
    output logic                    clear,
    output logic                    feed,
    output logic [Width/2-1:0]      word,
    output logic [Width-1:0]        expected,
    output logic [regAddrWidth-1:0] rdAddr
);
    localparam int HalfWidth = Width / 2;

    logic                    reqPend;     // request captured, response due next edge.
    logic                    reqWe;       // direction of the captured request.
    logic [regAddrWidth-1:0] reqAdr;      // captured word address.
    logic [31:0]             reqDat;      // captured write data.
    logic                    newReq;
    logic                    wrReq;

    // a stb still held while pending or acked belongs to the old transfer.
    assign newReq = cyc && stb && !reqPend && !ack;
    assign wrReq  = reqPend && reqWe;

    // the captured address also selects the read word in the result stage.
    assign rdAddr = reqAdr;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqPend <= 1'b0;
        end else begin
            reqPend <= newReq;            // first edge of the transfer.
        end
    end

    always_ff @(posedge clk) begin
        if (newReq) begin
            reqWe  <= we;
            reqAdr <= adr;
            reqDat <= datWr;
        end
    end

    // second edge: ack plus the one-cycle command pulses.
    always_ff @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            clear    <= 1'b0;
            feed     <= 1'b0;
            expected <= '0;
        end else begin
            ack   <= reqPend;
            clear <= wrReq && (reqAdr == regCtrl) && reqDat[0];
            feed  <= wrReq && (reqAdr == regData);
            if (wrReq && (reqAdr == regExpect)) begin
                expected <= Width'(reqDat);       // zero-extended for wide sums.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrReq && (reqAdr == regData)) begin
            word <= HalfWidth'(reqDat);   // low half-width bits only.
        end
        if (reqPend && !reqWe) begin
            datRd <= rdData;              // valid while ack is high.
        end
    end

endmodule
